//--- common/rammodel_pkg.sv
`default_nettype none

package rammodel_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int LEN_WIDTH  = 8;
    localparam int RESP_WIDTH = 2;

    // Buffer depths
    localparam int A_DEPTH = 8;
    localparam int W_DEPTH = 256;
    localparam int R_DEPTH = 256;
    localparam int B_DEPTH = 2;

    // Request record is {write, addr, len}
    localparam int A_WIDTH = 1 + ADDR_WIDTH + LEN_WIDTH;

    // Complete bursts held in the W buffer
    localparam int W_CNT_WIDTH = $clog2(W_DEPTH) + 1;

    typedef enum logic [2:0] {
        IDLE = 3'd0,
        DO_A = 3'd1,
        DO_W = 3'd2,
        DO_R = 3'd3,
        DO_B = 3'd4
    } sched_state_t;

endpackage

`default_nettype wire

//--- design/burst_fifo.sv
`default_nettype none

module burst_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  wire                     host_clk,
    input  wire                     host_rst,
    input  wire                     in_valid,
    output logic                    in_ready,
    input  wire  [WIDTH-1:0]        in_data,
    input  wire                     in_last,
    output logic                    out_valid,
    input  wire                     out_ready,
    output logic [WIDTH-1:0]        out_data,
    output logic                    out_last,
    output logic                    empty,
    output logic [$clog2(DEPTH):0]  bursts
);

    localparam int PTR_W = $clog2(DEPTH);

    // Entry is {last, data}
    logic [WIDTH:0] mem [DEPTH];
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           do_write;
    logic           do_read;

    // Extra pointer bit tells full from empty
    assign empty     = wr_ptr == rd_ptr;
    assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                       (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign in_ready  = !full;
    assign out_valid = !empty;
    assign do_write  = in_valid && in_ready;
    assign do_read   = out_valid && out_ready;

    assign {out_last, out_data} = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge host_clk) begin
        if (do_write) begin
            mem[wr_ptr[PTR_W-1:0]] <= {in_last, in_data};
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // One burst in per last beat written, one out per last beat read
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            bursts <= '0;
        end else begin
            case ({do_write && in_last, do_read && out_last})
                2'b10:   bursts <= bursts + 1'b1;
                2'b01:   bursts <= bursts - 1'b1;
                default: bursts <= bursts;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- intake/request_intake.sv
`default_nettype none

module request_intake (
    input  wire                                     host_clk,
    input  wire                                     host_rst,
    input  wire                                     target_fire,
    input  wire                                     frontend_avalid,
    output logic                                    frontend_aready,
    input  wire                                     frontend_awrite,
    input  wire  [rammodel_pkg::ADDR_WIDTH-1:0]     frontend_aaddr,
    input  wire  [rammodel_pkg::LEN_WIDTH-1:0]      frontend_alen,
    input  wire                                     frontend_wvalid,
    output logic                                    frontend_wready,
    input  wire  [rammodel_pkg::DATA_WIDTH-1:0]     frontend_wdata,
    input  wire                                     frontend_wlast,
    output logic                                    req_valid,
    input  wire                                     req_ready,
    output logic                                    req_write,
    output logic [rammodel_pkg::ADDR_WIDTH-1:0]     req_addr,
    output logic [rammodel_pkg::LEN_WIDTH-1:0]      req_len,
    output logic                                    wbuf_valid,
    input  wire                                     wbuf_ready,
    output logic [rammodel_pkg::DATA_WIDTH-1:0]     wbuf_data,
    output logic                                    wbuf_last,
    output logic [rammodel_pkg::W_CNT_WIDTH-1:0]    wbuf_bursts,
    output logic                                    intake_stall
);

    logic                               a_ready;
    logic                               w_ready;
    logic [rammodel_pkg::A_WIDTH-1:0]   req_rec;

    // Frontend moves only on fired cycles
    assign frontend_aready = a_ready && target_fire;
    assign frontend_wready = w_ready && target_fire;

    // Full buffer holds the target
    assign intake_stall = (frontend_avalid && !a_ready) || (frontend_wvalid && !w_ready);

    assign {req_write, req_addr, req_len} = req_rec;

    // Each request is a burst of one entry
    burst_fifo #(
        .WIDTH      (rammodel_pkg::A_WIDTH),
        .DEPTH      (rammodel_pkg::A_DEPTH)
    ) u_a_fifo (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .in_valid   (frontend_avalid && target_fire),
        .in_ready   (a_ready),
        .in_data    ({frontend_awrite, frontend_aaddr, frontend_alen}),
        .in_last    (1'b1),
        .out_valid  (req_valid),
        .out_ready  (req_ready),
        .out_data   (req_rec),
        .out_last   (),
        .empty      (),
        .bursts     ()
    );

    burst_fifo #(
        .WIDTH      (rammodel_pkg::DATA_WIDTH),
        .DEPTH      (rammodel_pkg::W_DEPTH)
    ) u_w_fifo (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .in_valid   (frontend_wvalid && target_fire),
        .in_ready   (w_ready),
        .in_data    (frontend_wdata),
        .in_last    (frontend_wlast),
        .out_valid  (wbuf_valid),
        .out_ready  (wbuf_ready),
        .out_data   (wbuf_data),
        .out_last   (wbuf_last),
        .empty      (),
        .bursts     (wbuf_bursts)
    );

endmodule

`default_nettype wire

//--- scheduler/access_scheduler.sv
`default_nettype none

module access_scheduler (
    input  wire                                     host_clk,
    input  wire                                     host_rst,
    input  wire                                     req_valid,
    output logic                                    req_ready,
    input  wire                                     req_write,
    input  wire  [rammodel_pkg::ADDR_WIDTH-1:0]     req_addr,
    input  wire  [rammodel_pkg::LEN_WIDTH-1:0]      req_len,
    input  wire                                     wbuf_valid,
    output logic                                    wbuf_ready,
    input  wire  [rammodel_pkg::DATA_WIDTH-1:0]     wbuf_data,
    input  wire                                     wbuf_last,
    input  wire  [rammodel_pkg::W_CNT_WIDTH-1:0]    wbuf_bursts,
    input  wire                                     b_empty,
    input  wire                                     r_empty,
    output logic                                    host_awvalid,
    input  wire                                     host_awready,
    output logic [rammodel_pkg::ADDR_WIDTH-1:0]     host_awaddr,
    output logic [rammodel_pkg::LEN_WIDTH-1:0]      host_awlen,
    output logic                                    host_wvalid,
    input  wire                                     host_wready,
    output logic [rammodel_pkg::DATA_WIDTH-1:0]     host_wdata,
    output logic                                    host_wlast,
    output logic                                    host_arvalid,
    input  wire                                     host_arready,
    output logic [rammodel_pkg::ADDR_WIDTH-1:0]     host_araddr,
    output logic [rammodel_pkg::LEN_WIDTH-1:0]      host_arlen,
    input  wire                                     host_bvalid,
    input  wire                                     host_bready,
    input  wire                                     host_rvalid,
    input  wire                                     host_rready,
    input  wire                                     host_rlast
);

    rammodel_pkg::sched_state_t sched_state;
    rammodel_pkg::sched_state_t sched_state_next;
    logic                       ok_to_start;
    logic                       in_a;
    logic                       in_w;
    logic                       a_fire;
    logic                       w_last_fire;
    logic                       b_fire;
    logic                       r_last_fire;

    assign a_fire      = req_valid && req_ready;
    assign w_last_fire = host_wvalid && host_wready && host_wlast;
    assign b_fire      = host_bvalid && host_bready;
    assign r_last_fire = host_rvalid && host_rready && host_rlast;

    // A write waits until its whole burst is buffered
    assign ok_to_start = req_valid && (!req_write || wbuf_bursts != '0) && b_empty && r_empty;

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            sched_state <= rammodel_pkg::IDLE;
        end else begin
            sched_state <= sched_state_next;
        end
    end

    always_comb begin
        sched_state_next = sched_state;
        case (sched_state)
            rammodel_pkg::IDLE: begin
                if (ok_to_start) begin
                    sched_state_next = rammodel_pkg::DO_A;
                end
            end
            rammodel_pkg::DO_A: begin
                if (a_fire) begin
                    sched_state_next = req_write ? rammodel_pkg::DO_W : rammodel_pkg::DO_R;
                end
            end
            rammodel_pkg::DO_W: begin
                if (w_last_fire) begin
                    sched_state_next = rammodel_pkg::DO_B;
                end
            end
            rammodel_pkg::DO_B: begin
                if (b_fire) begin
                    sched_state_next = rammodel_pkg::IDLE;
                end
            end
            rammodel_pkg::DO_R: begin
                if (r_last_fire) begin
                    sched_state_next = rammodel_pkg::IDLE;
                end
            end
            default: sched_state_next = rammodel_pkg::IDLE;
        endcase
    end

    assign in_a = sched_state == rammodel_pkg::DO_A;
    assign in_w = sched_state == rammodel_pkg::DO_W;

    // Write bit steers the head request to AW or AR
    assign host_awvalid = in_a && req_valid && req_write;
    assign host_arvalid = in_a && req_valid && !req_write;
    assign req_ready    = in_a && (req_write ? host_awready : host_arready);
    assign host_awaddr  = req_addr;
    assign host_awlen   = req_len;
    assign host_araddr  = req_addr;
    assign host_arlen   = req_len;

    assign host_wvalid = in_w && wbuf_valid;
    assign wbuf_ready  = in_w && host_wready;
    assign host_wdata  = wbuf_data;
    assign host_wlast  = wbuf_last;

endmodule

`default_nettype wire

//--- return/response_return.sv
`default_nettype none

module response_return (
    input  wire                                     host_clk,
    input  wire                                     host_rst,
    input  wire                                     target_fire,
    input  wire                                     breq_valid,
    input  wire                                     rreq_valid,
    input  wire                                     intake_stall,
    input  wire                                     host_bvalid,
    output logic                                    host_bready,
    input  wire  [rammodel_pkg::RESP_WIDTH-1:0]     host_bresp,
    input  wire                                     host_rvalid,
    output logic                                    host_rready,
    input  wire  [rammodel_pkg::DATA_WIDTH-1:0]     host_rdata,
    input  wire                                     host_rlast,
    output logic                                    frontend_bvalid,
    input  wire                                     frontend_bready,
    output logic [rammodel_pkg::RESP_WIDTH-1:0]     frontend_bresp,
    output logic                                    frontend_rvalid,
    input  wire                                     frontend_rready,
    output logic [rammodel_pkg::DATA_WIDTH-1:0]     frontend_rdata,
    output logic                                    frontend_rlast,
    output logic                                    b_empty,
    output logic                                    r_empty,
    output logic                                    stall
);

    logic b_gate;
    logic r_gate;
    logic b_head;
    logic r_head;

    // Released only on a fired cycle that asks for it
    assign b_gate = breq_valid && target_fire;
    assign r_gate = rreq_valid && target_fire;

    assign frontend_bvalid = b_head && b_gate;
    assign frontend_rvalid = r_head && r_gate;

    assign stall = intake_stall || (breq_valid && b_empty) || (rreq_valid && r_empty);

    burst_fifo #(
        .WIDTH      (rammodel_pkg::RESP_WIDTH),
        .DEPTH      (rammodel_pkg::B_DEPTH)
    ) u_b_fifo (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .in_valid   (host_bvalid),
        .in_ready   (host_bready),
        .in_data    (host_bresp),
        .in_last    (1'b1),
        .out_valid  (b_head),
        .out_ready  (frontend_bready && b_gate),
        .out_data   (frontend_bresp),
        .out_last   (),
        .empty      (b_empty),
        .bursts     ()
    );

    // Full R buffer holds the host
    burst_fifo #(
        .WIDTH      (rammodel_pkg::DATA_WIDTH),
        .DEPTH      (rammodel_pkg::R_DEPTH)
    ) u_r_fifo (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .in_valid   (host_rvalid),
        .in_ready   (host_rready),
        .in_data    (host_rdata),
        .in_last    (host_rlast),
        .out_valid  (r_head),
        .out_ready  (frontend_rready && r_gate),
        .out_data   (frontend_rdata),
        .out_last   (frontend_rlast),
        .empty      (r_empty),
        .bursts     ()
    );

endmodule

`default_nettype wire

//--- design/rammodel_backend.sv
`default_nettype none

module rammodel_backend (
    input  wire                                     host_clk,
    input  wire                                     host_rst,
    input  wire                                     frontend_avalid,
    output logic                                    frontend_aready,
    input  wire                                     frontend_awrite,
    input  wire  [rammodel_pkg::ADDR_WIDTH-1:0]     frontend_aaddr,
    input  wire  [rammodel_pkg::LEN_WIDTH-1:0]      frontend_alen,
    input  wire                                     frontend_wvalid,
    output logic                                    frontend_wready,
    input  wire  [rammodel_pkg::DATA_WIDTH-1:0]     frontend_wdata,
    input  wire                                     frontend_wlast,
    output logic                                    frontend_bvalid,
    input  wire                                     frontend_bready,
    output logic [rammodel_pkg::RESP_WIDTH-1:0]     frontend_bresp,
    output logic                                    frontend_rvalid,
    input  wire                                     frontend_rready,
    output logic [rammodel_pkg::DATA_WIDTH-1:0]     frontend_rdata,
    output logic                                    frontend_rlast,
    input  wire                                     breq_valid,
    input  wire                                     rreq_valid,
    input  wire                                     target_fire,
    output logic                                    stall,
    output logic                                    host_awvalid,
    input  wire                                     host_awready,
    output logic [rammodel_pkg::ADDR_WIDTH-1:0]     host_awaddr,
    output logic [rammodel_pkg::LEN_WIDTH-1:0]      host_awlen,
    output logic                                    host_wvalid,
    input  wire                                     host_wready,
    output logic [rammodel_pkg::DATA_WIDTH-1:0]     host_wdata,
    output logic                                    host_wlast,
    input  wire                                     host_bvalid,
    output logic                                    host_bready,
    input  wire  [rammodel_pkg::RESP_WIDTH-1:0]     host_bresp,
    output logic                                    host_arvalid,
    input  wire                                     host_arready,
    output logic [rammodel_pkg::ADDR_WIDTH-1:0]     host_araddr,
    output logic [rammodel_pkg::LEN_WIDTH-1:0]      host_arlen,
    input  wire                                     host_rvalid,
    output logic                                    host_rready,
    input  wire  [rammodel_pkg::DATA_WIDTH-1:0]     host_rdata,
    input  wire                                     host_rlast
);

    // Heads of the request and W buffers
    logic                                   req_valid;
    logic                                   req_ready;
    logic                                   req_write;
    logic [rammodel_pkg::ADDR_WIDTH-1:0]    req_addr;
    logic [rammodel_pkg::LEN_WIDTH-1:0]     req_len;
    logic                                   wbuf_valid;
    logic                                   wbuf_ready;
    logic [rammodel_pkg::DATA_WIDTH-1:0]    wbuf_data;
    logic                                   wbuf_last;
    logic [rammodel_pkg::W_CNT_WIDTH-1:0]   wbuf_bursts;

    logic                                   intake_stall;
    logic                                   b_empty;
    logic                                   r_empty;

    // Port names match across the three parts
    request_intake u_intake (.*);

    access_scheduler u_sched (.*);

    response_return u_return (.*);

endmodule

`default_nettype wire

//--- bench/rammodel_assert.sv
`default_nettype none

module rammodel_assert (
    input wire host_clk,
    input wire host_rst,
    input wire target_fire,
    input wire breq_valid,
    input wire rreq_valid,
    input wire stall,
    input wire frontend_avalid,
    input wire frontend_aready,
    input wire frontend_wvalid,
    input wire frontend_wready,
    input wire frontend_wlast,
    input wire frontend_bvalid,
    input wire frontend_bready,
    input wire frontend_rvalid,
    input wire frontend_rready,
    input wire host_awvalid,
    input wire host_awready,
    input wire host_wvalid,
    input wire host_wready,
    input wire host_wlast,
    input wire host_bvalid,
    input wire host_bready,
    input wire host_arvalid,
    input wire host_arready,
    input wire host_rvalid,
    input wire host_rready,
    input wire host_rlast
);

    rammodel_pkg::sched_state_t host_phase;
    int   bursts_pending;
    int   a_held;
    int   w_held;
    int   b_held;
    int   r_held;
    int   since_rst;
    logic stall_exp;
    logic a_take;
    logic w_take;
    logic aw_take;
    logic ar_take;
    logic hw_take;
    logic hb_take;
    logic hr_take;
    logic fb_take;
    logic fr_take;
    logic bad_gate = 1'b0;
    logic bad_resp = 1'b0;
    logic bad_overlap = 1'b0;
    logic bad_burst = 1'b0;
    logic bad_stall = 1'b0;
    logic bad_reset = 1'b0;
    logic any_failed;

    assign a_take  = frontend_avalid && frontend_aready;
    assign w_take  = frontend_wvalid && frontend_wready;
    assign aw_take = host_awvalid && host_awready;
    assign ar_take = host_arvalid && host_arready;
    assign hw_take = host_wvalid && host_wready;
    assign hb_take = host_bvalid && host_bready;
    assign hr_take = host_rvalid && host_rready;
    assign fb_take = frontend_bvalid && frontend_bready;
    assign fr_take = frontend_rvalid && frontend_rready;

    assign any_failed = bad_gate || bad_resp || bad_overlap || bad_burst ||
                        bad_stall || bad_reset;

    // Stall rebuilt from buffer occupancy
    assign stall_exp = (frontend_avalid && a_held == rammodel_pkg::A_DEPTH) ||
                       (frontend_wvalid && w_held == rammodel_pkg::W_DEPTH) ||
                       (breq_valid && b_held == 0) ||
                       (rreq_valid && r_held == 0);

    always @(posedge host_clk) begin
        if (host_rst) begin
            bursts_pending <= 0;
            a_held <= 0;
            w_held <= 0;
            b_held <= 0;
            r_held <= 0;
            since_rst <= 0;
        end else begin
            bursts_pending <= bursts_pending + int'(w_take && frontend_wlast) - int'(aw_take);
            a_held <= a_held + int'(a_take) - int'(aw_take || ar_take);
            w_held <= w_held + int'(w_take) - int'(hw_take);
            b_held <= b_held + int'(hb_take) - int'(fb_take);
            r_held <= r_held + int'(hr_take) - int'(fr_take);
            if (since_rst < 4) begin
                since_rst <= since_rst + 1;
            end
        end
    end

    // Host port phase as seen from the handshakes
    always @(posedge host_clk) begin
        if (host_rst) begin
            host_phase <= rammodel_pkg::IDLE;
        end else if (aw_take) begin
            host_phase <= rammodel_pkg::DO_W;
        end else if (ar_take) begin
            host_phase <= rammodel_pkg::DO_R;
        end else if (hw_take && host_wlast) begin
            host_phase <= rammodel_pkg::DO_B;
        end else if (hb_take || (hr_take && host_rlast)) begin
            host_phase <= rammodel_pkg::IDLE;
        end
    end

    assert property (@(posedge host_clk) disable iff (host_rst)
        (a_take || w_take) |-> target_fire)
    else begin
        bad_gate = 1'b1;
        $error("frontend A or W accepted without target_fire");
    end

    assert property (@(posedge host_clk) disable iff (host_rst)
        (!frontend_bvalid || (target_fire && breq_valid)) &&
        (!frontend_rvalid || (target_fire && rreq_valid)))
    else begin
        bad_resp = 1'b1;
        $error("frontend B or R valid outside a requested fired cycle");
    end

    assert property (@(posedge host_clk) disable iff (host_rst)
        !(host_awvalid && host_arvalid) &&
        (host_phase == rammodel_pkg::IDLE || !(host_awvalid || host_arvalid)))
    else begin
        bad_overlap = 1'b1;
        $error("host address issued while another transaction is open");
    end

    assert property (@(posedge host_clk) disable iff (host_rst)
        host_awvalid |-> bursts_pending > 0)
    else begin
        bad_burst = 1'b1;
        $error("host AW valid before its whole burst was accepted");
    end

    assert property (@(posedge host_clk) disable iff (host_rst)
        stall == stall_exp)
    else begin
        bad_stall = 1'b1;
        $error("stall does not follow the buffer state");
    end

    assert property (@(posedge host_clk) disable iff (host_rst)
        (since_rst < 4 && !breq_valid && !rreq_valid) |->
        !(host_awvalid || host_wvalid || host_arvalid || frontend_bvalid ||
          frontend_rvalid || stall))
    else begin
        bad_reset = 1'b1;
        $error("valid output or stall high right after reset");
    end

endmodule

bind rammodel_backend rammodel_assert u_chk (.*);

`default_nettype wire

//--- bench/tb_rammodel.sv
`default_nettype none

module tb_rammodel;

    localparam int LIMIT = 400;

    logic        host_clk = 1'b0;
    logic        host_rst = 1'b1;
    logic        target_fire = 1'b0;
    logic        breq_valid = 1'b0;
    logic        rreq_valid = 1'b0;
    logic        stall;

    logic        frontend_avalid = 1'b0;
    logic        frontend_aready;
    logic        frontend_awrite = 1'b0;
    logic [31:0] frontend_aaddr = '0;
    logic [7:0]  frontend_alen = '0;
    logic        frontend_wvalid = 1'b0;
    logic        frontend_wready;
    logic [63:0] frontend_wdata = '0;
    logic        frontend_wlast = 1'b0;
    logic        frontend_bvalid;
    logic        frontend_bready = 1'b0;
    logic [1:0]  frontend_bresp;
    logic        frontend_rvalid;
    logic        frontend_rready = 1'b0;
    logic [63:0] frontend_rdata;
    logic        frontend_rlast;

    logic        host_awvalid;
    logic        host_awready = 1'b0;
    logic [31:0] host_awaddr;
    logic [7:0]  host_awlen;
    logic        host_wvalid;
    logic        host_wready = 1'b0;
    logic [63:0] host_wdata;
    logic        host_wlast;
    logic        host_bvalid = 1'b0;
    logic        host_bready;
    logic [1:0]  host_bresp = 2'd0;
    logic        host_arvalid;
    logic        host_arready = 1'b0;
    logic [31:0] host_araddr;
    logic [7:0]  host_arlen;
    logic        host_rvalid = 1'b0;
    logic        host_rready;
    logic [63:0] host_rdata = '0;
    logic        host_rlast = 1'b0;

    // Host memory and the testbench's own record of what was written
    logic [63:0] hmem [64];
    logic [63:0] exp_mem [64];
    // Burst lengths of the writes sent, in order
    logic [7:0]  aw_len_q [$];
    logic [5:0]  hw_idx = '0;
    logic [5:0]  hr_idx = '0;
    logic [7:0]  hr_left = '0;
    logic        hr_busy = 1'b0;
    integer      seed = 53533;
    logic [31:0] rnd;

    rammodel_backend dut (.*);

    always #10 host_clk = ~host_clk;

    function automatic logic [63:0] mem_fill(input logic [5:0] idx);
        return {16'hf111, 10'd0, idx, ~{26'd0, idx}};
    endfunction

    function automatic logic [63:0] beat_data(input logic [31:0] addr, input int beat);
        return {addr, 24'h5a5a00, 8'(beat)};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("[ERROR] t=%0t %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic send_a(input logic write, input logic [31:0] addr, input logic [7:0] len);
        int n;
        n = 0;
        frontend_avalid <= 1'b1;
        frontend_awrite <= write;
        frontend_aaddr <= addr;
        frontend_alen <= len;
        @(posedge host_clk);
        while (!(frontend_avalid && frontend_aready)) begin
            n++;
            if (n > LIMIT) stop_with_failure("timeout waiting for the frontend A accept");
            @(posedge host_clk);
        end
        frontend_avalid <= 1'b0;
    endtask

    task automatic write_burst(input logic [31:0] addr, input int beats);
        int n;
        logic [5:0] idx;
        idx = addr[8:3];
        aw_len_q.push_back(8'(beats - 1));
        send_a(1'b1, addr, 8'(beats - 1));
        for (int i = 0; i < beats; i++) begin
            exp_mem[idx + 6'(i)] = beat_data(addr, i);
            frontend_wvalid <= 1'b1;
            frontend_wdata <= beat_data(addr, i);
            frontend_wlast <= (i == beats - 1);
            n = 0;
            @(posedge host_clk);
            while (!(frontend_wvalid && frontend_wready)) begin
                n++;
                if (n > LIMIT) stop_with_failure("timeout waiting for a frontend W accept");
                @(posedge host_clk);
            end
        end
        frontend_wvalid <= 1'b0;
        frontend_wlast <= 1'b0;
    endtask

    task automatic take_b();
        int n;
        n = 0;
        breq_valid <= 1'b1;
        frontend_bready <= 1'b1;
        @(posedge host_clk);
        while (!(frontend_bvalid && frontend_bready)) begin
            n++;
            if (n > LIMIT) stop_with_failure("timeout waiting for the write response");
            @(posedge host_clk);
        end
        check_value("frontend_bresp", {62'd0, frontend_bresp}, 64'd0);
        breq_valid <= 1'b0;
        frontend_bready <= 1'b0;
    endtask

    // Target asks for data before the read is even queued
    task automatic read_burst(input logic [31:0] addr, input int beats);
        int n;
        int got;
        logic [5:0] idx;
        n = 0;
        got = 0;
        idx = addr[8:3];
        rreq_valid <= 1'b1;
        frontend_rready <= 1'b1;
        repeat (3) @(posedge host_clk);
        send_a(1'b0, addr, 8'(beats - 1));
        while (got < beats) begin
            @(posedge host_clk);
            if (frontend_rvalid && frontend_rready) begin
                check_value("frontend_rdata", frontend_rdata, exp_mem[idx + 6'(got)]);
                check_value("frontend_rlast", {63'd0, frontend_rlast},
                            {63'd0, got == beats - 1});
                got++;
                n = 0;
            end else begin
                n++;
                if (n > LIMIT) stop_with_failure("timeout waiting for read data");
            end
        end
        rreq_valid <= 1'b0;
        frontend_rready <= 1'b0;
    endtask

    // Host port model with random readies, plus the random target_fire
    always @(posedge host_clk) begin
        rnd = $random(seed);
        if (host_rst) begin
            for (int i = 0; i < 64; i++) begin
                hmem[6'(i)] <= mem_fill(6'(i));
            end
            target_fire <= 1'b0;
            host_awready <= 1'b0;
            host_wready <= 1'b0;
            host_arready <= 1'b0;
            host_bvalid <= 1'b0;
            host_rvalid <= 1'b0;
            hr_busy <= 1'b0;
        end else begin
            target_fire <= rnd[0] | rnd[1];
            host_awready <= rnd[2];
            host_wready <= rnd[3];
            host_arready <= rnd[4];
            if (host_awvalid && host_awready) begin
                check_value("host_awlen", {56'd0, host_awlen}, {56'd0, aw_len_q.pop_front()});
                hw_idx <= host_awaddr[8:3];
            end
            if (host_wvalid && host_wready) begin
                hmem[hw_idx] <= host_wdata;
                hw_idx <= hw_idx + 6'd1;
                if (host_wlast) begin
                    host_bvalid <= 1'b1;
                end
            end
            if (host_bvalid && host_bready) begin
                host_bvalid <= 1'b0;
            end
            if (host_arvalid && host_arready) begin
                hr_idx <= host_araddr[8:3];
                hr_left <= host_arlen;
                hr_busy <= 1'b1;
            end
            if (!host_rvalid || host_rready) begin
                if (hr_busy && rnd[5]) begin
                    host_rvalid <= 1'b1;
                    host_rdata <= hmem[hr_idx];
                    host_rlast <= hr_left == 8'd0;
                    hr_idx <= hr_idx + 6'd1;
                    hr_left <= hr_left - 8'd1;
                    if (hr_left == 8'd0) begin
                        hr_busy <= 1'b0;
                    end
                end else begin
                    host_rvalid <= 1'b0;
                end
            end
        end
    end

    always @(posedge host_clk) begin
        if (dut.u_chk.any_failed) begin
            stop_with_failure("a protocol assertion failed");
        end
    end

    initial begin
        repeat (4) @(posedge host_clk);
        host_rst <= 1'b0;
        repeat (6) @(posedge host_clk);
        // Second write queues behind the first
        write_burst(32'h0000_0040, 4);
        write_burst(32'h0000_0100, 8);
        take_b();
        take_b();
        read_burst(32'h0000_0040, 4);
        read_burst(32'h0000_0100, 8);
        repeat (4) @(posedge host_clk);
        if (dut.u_chk.any_failed) begin
            stop_with_failure("a protocol assertion failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
common/rammodel_pkg.sv
design/burst_fifo.sv
intake/request_intake.sv
scheduler/access_scheduler.sv
return/response_return.sv
design/rammodel_backend.sv
bench/rammodel_assert.sv
bench/tb_rammodel.sv

//--- Makefile
TOP := tb_rammodel
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
